// ==== ipod_pkg.sv ====
package ipod_pkg;

  // ========================================
  // Bus and data widths
  // ========================================
  localparam int FLASH_ADDR_W = 23;
  localparam int FLASH_DATA_W = 32;
  localparam int SAMPLE_W     = 8;
  localparam int DIV_W        = 16;
  localparam int ASCII_W      = 8;
  localparam int SEG_W        = 7;
  localparam int HEX_DIGITS   = DIV_W / 4;
  localparam int STATE_W      = 2;

  // Audio region in flash, counted in 32-bit words
  localparam logic [FLASH_ADDR_W-1:0] LAST_WORD_ADDR = 23'h7FFFF;

  // ========================================
  // Playback rate
  // ========================================
  // About 22 kHz from the 50 MHz clock
  localparam logic [DIV_W-1:0] SAMPLE_DIV_DEFAULT = 16'd2272;
  localparam logic [DIV_W-1:0] SPEED_STEP         = 16'd16;
  localparam logic [DIV_W-1:0] DIV_MIN            = 16'd64;
  localparam logic [DIV_W-1:0] DIV_MAX            = 16'd65535;

  // Ten repeats per second while a button is held
  localparam int HOLD_REPEAT_CYCLES = 5_000_000;
  localparam int HOLD_W             = $clog2(HOLD_REPEAT_CYCLES);
  localparam logic [HOLD_W-1:0] HOLD_LAST = HOLD_W'(HOLD_REPEAT_CYCLES - 1);

  // ========================================
  // Keyboard commands, upper case ASCII
  // ========================================
  localparam logic [ASCII_W-1:0] CMD_PLAY        = 8'h45;
  localparam logic [ASCII_W-1:0] CMD_PAUSE       = 8'h44;
  localparam logic [ASCII_W-1:0] CMD_FWD         = 8'h46;
  localparam logic [ASCII_W-1:0] CMD_BACK        = 8'h42;
  localparam logic [ASCII_W-1:0] CMD_RESTART     = 8'h52;
  // Clearing bit 5 folds lower case letters onto upper case
  localparam logic [ASCII_W-1:0] ASCII_CASE_MASK = 8'hDF;

  // Reader FSM states
  localparam logic [STATE_W-1:0] ST_IDLE    = 2'd0;
  localparam logic [STATE_W-1:0] ST_REQ     = 2'd1;
  localparam logic [STATE_W-1:0] ST_WAIT    = 2'd2;
  localparam logic [STATE_W-1:0] ST_PRESENT = 2'd3;

  // Seven-segment patterns, segment a at bit 0, active low
  localparam logic [SEG_W-1:0] SEG_BLANK = 7'h7F;
  localparam logic [SEG_W-1:0] SEG_TABLE [16] = '{
    7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
    7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E
  };

endpackage

// ==== speed_ctrl.sv ====
`timescale 1ns/1ps

module speed_ctrl import ipod_pkg::*; (
  input  logic             CLK_50M,
  input  logic             rst_n,
  input  logic             key_faster,
  input  logic             key_slower,
  input  logic             key_default,
  output logic [DIV_W-1:0] div_count,
  output logic             sample_tick
);

  // Button bits are {default, slower, faster}
  logic [2:0]        btn_meta;
  logic [2:0]        btn_sync;
  logic [2:0]        btn_prev;
  logic [2:0]        btn_rise;
  logic              any_press;
  logic              any_held;
  logic              hold_due;
  logic              step_fire;
  logic [HOLD_W-1:0] hold_cnt;
  logic              step_faster;
  logic              step_slower;
  logic              step_default;
  logic [DIV_W-1:0]  tick_cnt;

  assign btn_rise  = btn_sync & ~btn_prev;
  assign any_press = |btn_rise;
  assign any_held  = |btn_sync;
  assign hold_due  = any_held && !any_press && (hold_cnt == HOLD_LAST);
  assign step_fire = any_press || hold_due;

  // ========================================
  // Synchronizers, press and repeat
  // ========================================
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      btn_meta     <= '0;
      btn_sync     <= '0;
      btn_prev     <= '0;
      hold_cnt     <= '0;
      step_faster  <= 1'b0;
      step_slower  <= 1'b0;
      step_default <= 1'b0;
    end
    else
    begin
      btn_meta <= {key_default, key_slower, key_faster};
      btn_sync <= btn_meta;
      btn_prev <= btn_sync;

      // Restart the repeat interval on every new press
      if (!any_held || any_press || hold_due)
        hold_cnt <= '0;
      else
        hold_cnt <= hold_cnt + HOLD_W'(1);

      // Default wins over slower, slower over faster
      step_default <= step_fire && btn_sync[2];
      step_slower  <= step_fire && btn_sync[1] && !btn_sync[2];
      step_faster  <= step_fire && btn_sync[0] && !btn_sync[2] && !btn_sync[1];
    end
  end

  // ========================================
  // Divider and sample tick
  // ========================================
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      div_count   <= SAMPLE_DIV_DEFAULT;
      tick_cnt    <= SAMPLE_DIV_DEFAULT - DIV_W'(1);
      sample_tick <= 1'b0;
    end
    else
    begin
      if (step_default)
        div_count <= SAMPLE_DIV_DEFAULT;
      else if (step_slower)
        div_count <= (div_count > DIV_MAX - SPEED_STEP) ? DIV_MAX : div_count + SPEED_STEP;
      else if (step_faster)
        div_count <= (div_count < DIV_MIN + SPEED_STEP) ? DIV_MIN : div_count - SPEED_STEP;

      // New divider only picked up on reload
      sample_tick <= (tick_cnt == '0);
      if (tick_cnt == '0)
        tick_cnt <= div_count - DIV_W'(1);
      else
        tick_cnt <= tick_cnt - DIV_W'(1);
    end
  end

endmodule

// ==== play_cmd_ctrl.sv ====
`timescale 1ns/1ps

module play_cmd_ctrl import ipod_pkg::*; (
  input  logic               CLK_50M,
  input  logic               rst_n,
  input  logic               kbd_valid,
  input  logic [ASCII_W-1:0] kbd_ascii,
  output logic               playing,
  output logic               reverse,
  output logic               restart
);

  logic [ASCII_W-1:0] cmd_char;
  logic               restart_seen;

  // Same command for either case of the letter
  assign cmd_char = kbd_ascii & ASCII_CASE_MASK;

  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      playing      <= 1'b0;
      reverse      <= 1'b0;
      restart_seen <= 1'b0;
      restart      <= 1'b0;
    end
    else
    begin
      // Restart goes out one cycle after the key is taken
      restart      <= restart_seen;
      restart_seen <= 1'b0;

      if (kbd_valid)
      begin
        case (cmd_char)
          CMD_PLAY:
            playing <= 1'b1;
          CMD_PAUSE:
            playing <= 1'b0;
          CMD_FWD:
            reverse <= 1'b0;
          CMD_BACK:
            reverse <= 1'b1;
          CMD_RESTART:
            restart_seen <= 1'b1;
          default:
          begin
            // Any other key leaves the state alone
          end
        endcase
      end
    end
  end

endmodule

// ==== flash_sample_reader.sv ====
`timescale 1ns/1ps

module flash_sample_reader import ipod_pkg::*; (
  input  logic                    CLK_50M,
  input  logic                    rst_n,
  input  logic                    sample_tick,
  input  logic                    playing,
  input  logic                    reverse,
  input  logic                    restart,
  input  logic                    flash_waitrequest,
  input  logic                    flash_readdatavalid,
  input  logic [FLASH_DATA_W-1:0] flash_readdata,
  output logic                    flash_read,
  output logic [FLASH_ADDR_W-1:0] flash_address,
  output logic [SAMPLE_W-1:0]     audio_sample,
  output logic                    sample_valid
);

  logic [STATE_W-1:0]      state;
  logic [FLASH_ADDR_W-1:0] word_addr;
  logic                    half_upper;
  logic                    dir_q;
  logic                    loaded;
  logic                    pending;
  logic                    drop_data;
  logic [FLASH_DATA_W-1:0] word_data;
  logic [FLASH_ADDR_W-1:0] next_addr;
  logic                    next_upper;
  logic                    tick_hit;
  logic                    start_step;

  assign tick_hit   = sample_tick && playing;
  assign start_step = playing && (sample_tick || pending);

  // One sample step in the current direction, wraps at both ends
  always_comb
  begin
    next_addr  = word_addr;
    next_upper = ~half_upper;
    if (!reverse && half_upper)
      next_addr = (word_addr == LAST_WORD_ADDR) ? '0 : word_addr + FLASH_ADDR_W'(1);
    else if (reverse && !half_upper)
      next_addr = (word_addr == '0) ? LAST_WORD_ADDR : word_addr - FLASH_ADDR_W'(1);
  end

  // ========================================
  // Reader FSM
  // ========================================
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      state         <= ST_IDLE;
      word_addr     <= '0;
      half_upper    <= 1'b0;
      dir_q         <= 1'b0;
      loaded        <= 1'b0;
      pending       <= 1'b0;
      drop_data     <= 1'b0;
      flash_read    <= 1'b0;
      flash_address <= '0;
      audio_sample  <= '0;
      sample_valid  <= 1'b0;
    end
    else
    begin
      sample_valid <= 1'b0;
      case (state)
        ST_IDLE:
        begin
          if (!restart && reverse != dir_q)
          begin
            // Direction flipped, step back over the sample just played
            word_addr  <= next_addr;
            half_upper <= next_upper;
            dir_q      <= reverse;
            if (next_addr != word_addr)
              loaded <= 1'b0;
            if (tick_hit)
              pending <= 1'b1;
          end
          else if (!restart && start_step)
          begin
            pending <= 1'b0;
            if (loaded)
              state <= ST_PRESENT;
            else
            begin
              flash_read    <= 1'b1;
              flash_address <= word_addr;
              state         <= ST_REQ;
            end
          end
        end
        ST_REQ:
        begin
          if (!flash_waitrequest)
          begin
            flash_read <= 1'b0;
            state      <= ST_WAIT;
          end
        end
        ST_WAIT:
        begin
          if (flash_readdatavalid)
          begin
            drop_data <= 1'b0;
            if (drop_data || restart)
              state <= ST_IDLE;
            else
            begin
              loaded <= 1'b1;
              state  <= ST_PRESENT;
            end
          end
        end
        ST_PRESENT:
        begin
          audio_sample <= half_upper ? word_data[FLASH_DATA_W-1 -: SAMPLE_W]
                                     : word_data[FLASH_DATA_W/2-1 -: SAMPLE_W];
          sample_valid <= 1'b1;
          word_addr    <= next_addr;
          half_upper   <= next_upper;
          dir_q        <= reverse;
          if (next_addr != word_addr)
            loaded <= 1'b0;
          state <= ST_IDLE;
        end
        default:
          state <= ST_IDLE;
      endcase

      // Only one tick is kept while busy
      if (tick_hit && state != ST_IDLE)
        pending <= 1'b1;

      // Restart overrides the step; a fetch in flight completes unused
      if (restart)
      begin
        word_addr  <= reverse ? LAST_WORD_ADDR : '0;
        half_upper <= reverse;
        dir_q      <= reverse;
        loaded     <= 1'b0;
        pending    <= 1'b0;
        if (state == ST_REQ || (state == ST_WAIT && !flash_readdatavalid))
          drop_data <= 1'b1;
        if (state == ST_PRESENT)
        begin
          sample_valid <= 1'b0;
          state        <= ST_IDLE;
        end
      end
    end
  end

  always_ff @(posedge CLK_50M)
  begin
    if (state == ST_WAIT && flash_readdatavalid)
      word_data <= flash_readdata;
  end

endmodule

// ==== hex_display.sv ====
`timescale 1ns/1ps

module hex_display import ipod_pkg::*; (
  input  logic             CLK_50M,
  input  logic             rst_n,
  input  logic [DIV_W-1:0] div_count,
  output logic [SEG_W-1:0] hex0,
  output logic [SEG_W-1:0] hex1,
  output logic [SEG_W-1:0] hex2,
  output logic [SEG_W-1:0] hex3
);

  // Digit 0 holds the lowest nibble
  logic [SEG_W-1:0] seg [HEX_DIGITS];

  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < HEX_DIGITS; i++)
        seg[i] <= SEG_BLANK;
    end
    else
    begin
      for (int i = 0; i < HEX_DIGITS; i++)
        seg[i] <= SEG_TABLE[div_count[4*i +: 4]];
    end
  end

  assign hex0 = seg[0];
  assign hex1 = seg[1];
  assign hex2 = seg[2];
  assign hex3 = seg[3];

endmodule

// ==== simple_ipod.sv ====
`timescale 1ns/1ps

module simple_ipod import ipod_pkg::*; (
  input  logic                    CLK_50M,
  input  logic                    rst_n,
  input  logic                    key_faster,
  input  logic                    key_slower,
  input  logic                    key_default,
  input  logic                    kbd_valid,
  input  logic [ASCII_W-1:0]      kbd_ascii,
  input  logic                    flash_waitrequest,
  input  logic                    flash_readdatavalid,
  input  logic [FLASH_DATA_W-1:0] flash_readdata,
  output logic                    flash_read,
  output logic [FLASH_ADDR_W-1:0] flash_address,
  output logic [SAMPLE_W-1:0]     audio_sample,
  output logic                    sample_valid,
  output logic [SEG_W-1:0]        hex0,
  output logic [SEG_W-1:0]        hex1,
  output logic [SEG_W-1:0]        hex2,
  output logic [SEG_W-1:0]        hex3
);

  logic [DIV_W-1:0] div_count;
  logic             sample_tick;
  logic             playing;
  logic             reverse;
  logic             restart;

  // ========================================
  // Rate and command control
  // ========================================
  speed_ctrl u_speed_ctrl (
    .CLK_50M     (CLK_50M),
    .rst_n       (rst_n),
    .key_faster  (key_faster),
    .key_slower  (key_slower),
    .key_default (key_default),
    .div_count   (div_count),
    .sample_tick (sample_tick)
  );

  play_cmd_ctrl u_play_cmd_ctrl (
    .CLK_50M   (CLK_50M),
    .rst_n     (rst_n),
    .kbd_valid (kbd_valid),
    .kbd_ascii (kbd_ascii),
    .playing   (playing),
    .reverse   (reverse),
    .restart   (restart)
  );

  // ========================================
  // Flash playback and display
  // ========================================
  flash_sample_reader u_flash_sample_reader (
    .CLK_50M             (CLK_50M),
    .rst_n               (rst_n),
    .sample_tick         (sample_tick),
    .playing             (playing),
    .reverse             (reverse),
    .restart             (restart),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdatavalid (flash_readdatavalid),
    .flash_readdata      (flash_readdata),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .audio_sample        (audio_sample),
    .sample_valid        (sample_valid)
  );

  hex_display u_hex_display (
    .CLK_50M   (CLK_50M),
    .rst_n     (rst_n),
    .div_count (div_count),
    .hex0      (hex0),
    .hex1      (hex1),
    .hex2      (hex2),
    .hex3      (hex3)
  );

endmodule

// ==== tb_flash_model.sv ====
`timescale 1ns/1ps

module tb_flash_model import ipod_pkg::*; (
  input  logic                    CLK_50M,
  input  logic                    flash_read,
  input  logic [FLASH_ADDR_W-1:0] flash_address,
  output logic                    flash_waitrequest,
  output logic                    flash_readdatavalid,
  output logic [FLASH_DATA_W-1:0] flash_readdata
);

  logic [31:0]             lfsr;
  logic                    in_access;
  logic                    in_latency;
  logic [1:0]              wait_left;
  logic [1:0]              lat_left;
  logic [FLASH_ADDR_W-1:0] req_addr;

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // Two fresh bits, one step per bit
  task automatic draw_count(output logic [1:0] cnt);
    lfsr   = lfsr_step(lfsr);
    cnt[1] = lfsr[0];
    lfsr   = lfsr_step(lfsr);
    cnt[0] = lfsr[0];
  endtask

  // Lower half is the address, upper half its inverse
  function automatic logic [FLASH_DATA_W-1:0] word_rule(input logic [FLASH_ADDR_W-1:0] a);
    return {~a[15:0], a[15:0]};
  endfunction

  // ========================================
  // Responder, driven on the falling edge
  // ========================================
  initial
  begin
    lfsr                = 32'h801a;
    in_access           = 1'b0;
    in_latency          = 1'b0;
    wait_left           = 2'd0;
    lat_left            = 2'd0;
    req_addr            = '0;
    flash_waitrequest   = 1'b1;
    flash_readdatavalid = 1'b0;
    flash_readdata      = '0;
    forever
    begin
      @(negedge CLK_50M);
      flash_readdatavalid = 1'b0;
      if (in_latency)
      begin
        if (lat_left == 2'd0)
        begin
          flash_readdatavalid = 1'b1;
          flash_readdata      = word_rule(req_addr);
          in_latency          = 1'b0;
        end
        else
          lat_left = lat_left - 2'd1;
      end
      else if (in_access)
      begin
        if (!flash_waitrequest)
        begin
          // Request taken on the last rising edge
          flash_waitrequest = 1'b1;
          in_access         = 1'b0;
          in_latency        = 1'b1;
        end
        else
        begin
          wait_left = wait_left - 2'd1;
          if (wait_left == 2'd0)
            flash_waitrequest = 1'b0;
        end
      end
      else if (flash_read)
      begin
        req_addr = flash_address;
        draw_count(wait_left);
        draw_count(lat_left);
        flash_waitrequest = (wait_left != 2'd0);
        in_access         = 1'b1;
      end
    end
  end

endmodule

// ==== tb_simple_ipod.sv ====
`timescale 1ns/1ps

module tb_simple_ipod import ipod_pkg::*; ();

  logic                    CLK_50M;
  logic                    rst_n;
  logic                    key_faster;
  logic                    key_slower;
  logic                    key_default;
  logic                    kbd_valid;
  logic [ASCII_W-1:0]      kbd_ascii;
  logic                    flash_waitrequest;
  logic                    flash_readdatavalid;
  logic [FLASH_DATA_W-1:0] flash_readdata;
  logic                    flash_read;
  logic [FLASH_ADDR_W-1:0] flash_address;
  logic [SAMPLE_W-1:0]     audio_sample;
  logic                    sample_valid;
  logic [SEG_W-1:0]        hex0;
  logic [SEG_W-1:0]        hex1;
  logic [SEG_W-1:0]        hex2;
  logic [SEG_W-1:0]        hex3;

  int                      hs_errors;
  int                      value_errors;
  int                      timeouts;
  int                      period;
  int                      base;
  logic [SAMPLE_W-1:0]     sample_q [$];
  logic [FLASH_ADDR_W-1:0] fetch_q [$];
  logic                    outstanding;
  logic                    hold_prev;
  logic [FLASH_ADDR_W-1:0] addr_prev;

  simple_ipod u_simple_ipod (
    .CLK_50M             (CLK_50M),
    .rst_n               (rst_n),
    .key_faster          (key_faster),
    .key_slower          (key_slower),
    .key_default         (key_default),
    .kbd_valid           (kbd_valid),
    .kbd_ascii           (kbd_ascii),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdatavalid (flash_readdatavalid),
    .flash_readdata      (flash_readdata),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .audio_sample        (audio_sample),
    .sample_valid        (sample_valid),
    .hex0                (hex0),
    .hex1                (hex1),
    .hex2                (hex2),
    .hex3                (hex3)
  );

  tb_flash_model u_flash (
    .CLK_50M             (CLK_50M),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdatavalid (flash_readdatavalid),
    .flash_readdata      (flash_readdata)
  );

  initial CLK_50M = 1'b0;
  always #10 CLK_50M = ~CLK_50M;

  // ========================================
  // Bus monitor
  // ========================================
  always @(posedge CLK_50M)
  begin
    if (rst_n && hold_prev)
    begin
      assert (flash_read)
      else
      begin
        hs_errors++;
        $display("** Error %0t flash_read expected 1 actual %0b", $time, flash_read);
      end
      assert (flash_address == addr_prev)
      else
      begin
        hs_errors++;
        $display("** Error %0t flash_address expected %h actual %h", $time, addr_prev,
                 flash_address);
      end
    end
    if (rst_n && sample_valid)
      sample_q.push_back(audio_sample);
    if (rst_n && flash_read && !flash_waitrequest)
      fetch_q.push_back(flash_address);
    hold_prev <= rst_n && flash_read && flash_waitrequest;
    addr_prev <= flash_address;
    if (!rst_n)
      outstanding <= 1'b0;
    else if (flash_read && !flash_waitrequest)
      outstanding <= 1'b1;
    else if (flash_readdatavalid)
      outstanding <= 1'b0;
  end

  // One read at a time
  assert property (@(posedge CLK_50M) disable iff (!rst_n) !(outstanding && flash_read))
  else
  begin
    hs_errors++;
    $display("** Error %0t flash_read expected 0 actual 1 with a read outstanding", $time);
  end

  function automatic logic [SAMPLE_W-1:0] expected_sample(input logic [FLASH_ADDR_W-1:0] a,
                                                          input logic upper);
    return upper ? ~a[15:8] : a[15:8];
  endfunction

  // Active low, segment a at bit 0
  function automatic logic [SEG_W-1:0] seg_of(input logic [3:0] d);
    case (d)
      4'h0: return 7'h40;
      4'h1: return 7'h79;
      4'h2: return 7'h24;
      4'h3: return 7'h30;
      4'h4: return 7'h19;
      4'h5: return 7'h12;
      4'h6: return 7'h02;
      4'h7: return 7'h78;
      4'h8: return 7'h00;
      4'h9: return 7'h10;
      4'hA: return 7'h08;
      4'hB: return 7'h03;
      4'hC: return 7'h46;
      4'hD: return 7'h21;
      4'hE: return 7'h06;
      default: return 7'h0E;
    endcase
  endfunction

  task automatic check_equal(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (expected == actual)
    else
    begin
      value_errors++;
      $display("** Error %0t %s expected %0h actual %0h", $time, name, expected, actual);
    end
  endtask

  task automatic wait_cycles(input int n);
    for (int i = 0; i < n; i++)
      @(negedge CLK_50M);
  endtask

  task automatic send_key(input logic [ASCII_W-1:0] c);
    @(negedge CLK_50M);
    kbd_valid = 1'b1;
    kbd_ascii = c;
    @(negedge CLK_50M);
    kbd_valid = 1'b0;
    wait_cycles(4);
  endtask

  // Keys are {default, slower, faster}
  task automatic press_button(input logic [2:0] keys);
    @(negedge CLK_50M);
    {key_default, key_slower, key_faster} = keys;
    wait_cycles(8);
    {key_default, key_slower, key_faster} = 3'b000;
  endtask

  task automatic wait_samples(input int n);
    int guard;
    guard = 0;
    while (sample_q.size() < n && guard < n * (2 * period + 200))
    begin
      @(negedge CLK_50M);
      guard++;
    end
    if (sample_q.size() < n)
    begin
      timeouts++;
      $display("Timed out waiting for %0d samples, only %0d arrived", n, sample_q.size());
    end
  endtask

  task automatic check_sample(input int idx, input logic [FLASH_ADDR_W-1:0] a,
                              input logic upper);
    if (idx < sample_q.size())
      check_equal($sformatf("audio_sample #%0d", idx), 32'(expected_sample(a, upper)),
                  32'(sample_q[idx]));
  endtask

  task automatic check_fetch(input int idx, input logic [FLASH_ADDR_W-1:0] a);
    if (idx < fetch_q.size())
      check_equal($sformatf("flash_address fetch #%0d", idx), 32'(a), 32'(fetch_q[idx]));
    else
    begin
      value_errors++;
      $display("Fetch #%0d never reached the flash", idx);
    end
  endtask

  task automatic expect_display(input logic [DIV_W-1:0] div);
    logic [4*SEG_W-1:0] want;
    int                 guard;
    want  = {seg_of(div[15:12]), seg_of(div[11:8]), seg_of(div[7:4]), seg_of(div[3:0])};
    guard = 0;
    while ({hex3, hex2, hex1, hex0} != want && guard < 20)
    begin
      @(negedge CLK_50M);
      guard++;
    end
    if ({hex3, hex2, hex1, hex0} != want)
    begin
      timeouts++;
      $display("Display never settled on divider %h", div);
    end
    // Still one step later on
    wait_cycles(10);
    check_equal("hex0", 32'(want[6:0]), 32'(hex0));
    check_equal("hex1", 32'(want[13:7]), 32'(hex1));
    check_equal("hex2", 32'(want[20:14]), 32'(hex2));
    check_equal("hex3", 32'(want[27:21]), 32'(hex3));
  endtask

  initial
  begin
    rst_n        = 1'b0;
    key_faster   = 1'b0;
    key_slower   = 1'b0;
    key_default  = 1'b0;
    kbd_valid    = 1'b0;
    kbd_ascii    = '0;
    hs_errors    = 0;
    value_errors = 0;
    timeouts     = 0;
    period       = int'(SAMPLE_DIV_DEFAULT);
    wait_cycles(4);
    rst_n = 1'b1;
    wait_cycles(2);

    check_equal("flash_read", 32'd0, 32'(flash_read));
    check_equal("sample_valid", 32'd0, 32'(sample_valid));
    check_equal("audio_sample", 32'd0, 32'(audio_sample));
    expect_display(SAMPLE_DIV_DEFAULT);

    // ========================================
    // Speed buttons
    // ========================================
    press_button(3'b001);
    expect_display(SAMPLE_DIV_DEFAULT - SPEED_STEP);
    press_button(3'b010);
    expect_display(SAMPLE_DIV_DEFAULT);
    press_button(3'b010);
    expect_display(SAMPLE_DIV_DEFAULT + SPEED_STEP);
    press_button(3'b100);
    expect_display(SAMPLE_DIV_DEFAULT);

    // ========================================
    // Forward play and pause
    // ========================================
    send_key("R");
    sample_q.delete();
    fetch_q.delete();
    send_key("E");
    wait_samples(6);
    for (int i = 0; i < 6; i++)
      check_sample(i, FLASH_ADDR_W'(i / 2), (i % 2) == 1);
    for (int i = 0; i < 3; i++)
      check_fetch(i, FLASH_ADDR_W'(i));
    base = sample_q.size();
    send_key("D");
    wait_cycles(3 * period);
    assert (sample_q.size() - base <= 1)
    else
    begin
      value_errors++;
      $display("** Error %0t sample_valid pulses after pause expected <=1 actual %0d", $time,
               sample_q.size() - base);
    end
    base = sample_q.size();
    wait_cycles(3 * period);
    check_equal("sample_valid pulses while paused", 32'd0, 32'(sample_q.size() - base));

    // Reverse from the end of the region
    send_key("R");
    send_key("B");
    sample_q.delete();
    fetch_q.delete();
    send_key("E");
    wait_samples(4);
    check_sample(0, LAST_WORD_ADDR, 1'b1);
    check_sample(1, LAST_WORD_ADDR, 1'b0);
    check_sample(2, LAST_WORD_ADDR - FLASH_ADDR_W'(1), 1'b1);
    check_sample(3, LAST_WORD_ADDR - FLASH_ADDR_W'(1), 1'b0);
    check_fetch(0, LAST_WORD_ADDR);
    check_fetch(1, LAST_WORD_ADDR - FLASH_ADDR_W'(1));

    // Turn around at word 0, lower case keys this time
    send_key("d");
    wait_cycles(3 * period);
    send_key("f");
    send_key("r");
    sample_q.delete();
    fetch_q.delete();
    send_key("e");
    wait_samples(1);
    send_key("b");
    wait_samples(3);
    check_sample(0, '0, 1'b0);
    check_sample(1, '0, 1'b0);
    check_sample(2, LAST_WORD_ADDR, 1'b1);
    check_fetch(0, '0);
    check_fetch(1, LAST_WORD_ADDR);

    $display("Errors: handshake %0d, values %0d, timeouts %0d", hs_errors, value_errors,
             timeouts);
    if (hs_errors + value_errors + timeouts == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

// ==== simple_ipod.f ====
ipod_pkg.sv
speed_ctrl.sv
play_cmd_ctrl.sv
flash_sample_reader.sv
hex_display.sv
simple_ipod.sv
tb_flash_model.sv
tb_simple_ipod.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1

rm -f sim.log
verilator --binary --timing --assert -f simple_ipod.f \
  --top-module tb_simple_ipod -o sim_tb_simple_ipod \
  && ./obj_dir/sim_tb_simple_ipod | tee sim.log \
  && grep -q "^Done: no errors$" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
